/* phold.f */
hw/phold_pkg.sv
hw/rr_arbiter.sv
hw/event_queue.sv
hw/lfsr_prng.sv
hw/phold_core.sv
hw/gvt_tracker.sv
hw/phold_engine.sv
bench/phold_assert.sv
bench/phold_tb.sv

/* bench/phold_tb.sv */
`timescale 1ns/1ps

module phold_tb;
   import phold_pkg::*;

   localparam int TIMEOUT_CYC = 40000;   // end_time 400, 8 LPs, about 12 cycles per event
   localparam int RUN_SEED    = 73;

   logic      clk;
   logic      rst_n;
   sim_time_t end_time;
   rand_t     seed;
   sim_time_t gvt, disp_time, spawn_time;
   logic      done, disp_vld, spawn_vld, spawn_init;
   core_id_t  disp_core, spawn_core;
   lp_id_t    disp_lp, spawn_lp;

   // model: queued events in arrival order plus one held event per core
   sim_time_t q_time [$];
   lp_id_t    q_lp   [$];
   logic      held_vld  [NUM_CORE] = '{default: 1'b0};
   sim_time_t held_time [NUM_CORE];

   int        init_cnt  = 0;
   int        disp_cnt  = 0;
   int        cycle_cnt = 0;
   sim_time_t prev_gvt  = '0;
   logic      prev_done = 1'b0;
   logic      prev_op   = 1'b0;
   logic      done_seen = 1'b0;

   phold_engine i_dut (
      .clk        (clk),
      .rst_n      (rst_n),
      .end_time   (end_time),
      .seed       (seed),
      .gvt        (gvt),
      .done       (done),
      .disp_vld   (disp_vld),
      .disp_core  (disp_core),
      .disp_lp    (disp_lp),
      .disp_time  (disp_time),
      .spawn_vld  (spawn_vld),
      .spawn_init (spawn_init),
      .spawn_core (spawn_core),
      .spawn_lp   (spawn_lp),
      .spawn_time (spawn_time)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   task automatic fail_run(input string msg);
      $display("ERROR at %0t ns: %s", $time, msg);
      $display("Something failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_time(input string what, input sim_time_t got, input sim_time_t exp);
      if (got !== exp)
         fail_run($sformatf("%s: got %0d, expected %0d", what, got, exp));
   endtask

   task automatic check_lp(input string what, input lp_id_t got, input lp_id_t exp);
      if (got !== exp)
         fail_run($sformatf("%s: got %0d, expected %0d", what, got, exp));
   endtask

   task automatic check_core(input string what, input core_id_t got, input core_id_t exp);
      if (got !== exp)
         fail_run($sformatf("%s: got %0d, expected %0d", what, got, exp));
   endtask

   // earliest time over queued and held events
   function automatic bit model_min(output sim_time_t min_t);
      bit vld;
      vld   = 1'b0;
      min_t = '0;
      foreach (q_time[i]) begin
         if (!vld || q_time[i] < min_t) begin
            vld   = 1'b1;
            min_t = q_time[i];
         end
      end
      for (int c = 0; c < NUM_CORE; c++) begin
         if (held_vld[c] && (!vld || held_time[c] < min_t)) begin
            vld   = 1'b1;
            min_t = held_time[c];
         end
      end
      return vld;
   endfunction

   function automatic int held_count();
      int n;
      n = 0;
      for (int c = 0; c < NUM_CORE; c++)
         n += held_vld[c];
      return n;
   endfunction

   task automatic check_gvt();
      sim_time_t lim;
      if (gvt < prev_gvt)
         fail_run($sformatf("gvt fell from %0d to %0d", prev_gvt, gvt));
      if (model_min(lim) && gvt > lim)
         fail_run($sformatf("gvt %0d above earliest model event %0d", gvt, lim));
   endtask

   task automatic take_spawn();
      sim_time_t hop;
      if (spawn_init) begin
         if (init_cnt >= NUM_LP || disp_cnt != 0)
            fail_run("initial spawn after the initial load");
         check_time("initial spawn time", spawn_time, sim_time_t'(0));
         check_lp("initial spawn lp", spawn_lp, lp_id_t'(init_cnt));
         init_cnt++;
      end else begin
         if (init_cnt != NUM_LP)
            fail_run("core spawn before the initial load finished");
         if (!held_vld[spawn_core])
            fail_run($sformatf("spawn from core %0d that holds no event", spawn_core));
         hop = spawn_time - held_time[spawn_core];
         if (hop < 1 || hop > (1 << NB_INC))
            fail_run($sformatf("spawn time %0d not 1 to 8 after %0d",
                               spawn_time, held_time[spawn_core]));
         held_vld[spawn_core] = 1'b0;
      end
      q_time.push_back(spawn_time);
      q_lp.push_back(spawn_lp);
   endtask

   task automatic take_dispatch();
      int pick;
      if (done)
         fail_run("dispatch while done is high");
      if (init_cnt != NUM_LP)
         fail_run("dispatch before the initial load finished");
      if (q_time.size() == 0)
         fail_run("dispatch while the model queue is empty");
      if (held_vld[disp_core])
         fail_run($sformatf("dispatch to core %0d that still holds an event", disp_core));
      if (disp_time < gvt)
         fail_run($sformatf("dispatch time %0d below gvt %0d", disp_time, gvt));
      // all cores idle at first, round robin serves them in order
      if (disp_cnt < NUM_CORE)
         check_core("first round dispatch core", disp_core, core_id_t'(disp_cnt));
      pick = 0;
      for (int i = 1; i < q_time.size(); i++)
         if (q_time[i] < q_time[pick])
            pick = i;   // strict less keeps the oldest among equals
      check_time("dispatch time", disp_time, q_time[pick]);
      check_lp("dispatch lp", disp_lp, q_lp[pick]);
      q_time.delete(pick);
      q_lp.delete(pick);
      held_vld[disp_core]  = 1'b1;
      held_time[disp_core] = disp_time;
      disp_cnt++;
   endtask

   // outputs settle well before the falling edge
   always @(negedge clk) begin
      if (rst_n) begin
         check_gvt();
         if (prev_done && !done)
            fail_run("done fell after it was raised");
         if (prev_gvt > end_time && !done)
            fail_run("done not raised after gvt passed end_time");
         if (done && !prev_done && !(gvt > end_time))
            fail_run($sformatf("done raised with gvt %0d not past %0d", gvt, end_time));
         if (disp_vld && spawn_vld)
            fail_run("dispatch and spawn in the same cycle");
         if (prev_op && (disp_vld || spawn_vld))
            fail_run("queue operation right after another");
         if (spawn_vld)
            take_spawn();
         if (disp_vld)
            take_dispatch();
         if (done)
            done_seen = 1'b1;
         prev_gvt  = gvt;
         prev_done = done;
         prev_op   = disp_vld || spawn_vld;
      end
   end

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt == TIMEOUT_CYC) begin
         $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
         $display("Something failed");
         $fatal(1, "timeout");
      end
   end

   initial begin
      void'($urandom(RUN_SEED));
      rst_n    = 1'b0;
      end_time = '0;
      seed     = '0;
      @(posedge clk);
      seed     <= rand_t'($urandom());
      end_time <= sim_time_t'(200 + ($urandom() % 201));
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;
      while (!done_seen)
         @(posedge clk);
      while (held_count() != 0)   // pending spawns drain after done
         @(posedge clk);
      if (disp_cnt == 0) begin
         fail_run("no event was dispatched");
      end else begin
         $display("Everything OK");
         $finish;
      end
   end

endmodule

/* bench/phold_assert.sv */
`timescale 1ns/1ps

module phold_assert (
   input logic                 clk,
   input logic                 rst_n,
   input logic                 disp_vld,
   input logic                 spawn_vld,
   input logic                 done,
   input phold_pkg::sim_time_t gvt
);

   a_one_op: assert property (@(posedge clk) disable iff (!rst_n)
      !(disp_vld && spawn_vld))
      else $error("dispatch and spawn in the same cycle");

   // queue is busy for a cycle after any operation
   a_op_gap: assert property (@(posedge clk) disable iff (!rst_n)
      (disp_vld || spawn_vld) |=> !(disp_vld || spawn_vld))
      else $error("queue operation right after another");

   a_done_hold: assert property (@(posedge clk) disable iff (!rst_n)
      done |=> done)
      else $error("done fell");

   a_gvt_mono: assert property (@(posedge clk) disable iff (!rst_n)
      gvt >= $past(gvt))
      else $error("gvt decreased");

endmodule

bind phold_engine phold_assert i_assert (
   .clk       (clk),
   .rst_n     (rst_n),
   .disp_vld  (disp_vld),
   .spawn_vld (spawn_vld),
   .done      (done),
   .gvt       (gvt)
);

/* hw/phold_engine.sv */
`timescale 1ns/1ps

module phold_engine (
   input  logic                 clk,
   input  logic                 rst_n,
   input  phold_pkg::sim_time_t end_time,
   input  phold_pkg::rand_t     seed,
   output phold_pkg::sim_time_t gvt,
   output logic                 done,
   output logic                 disp_vld,
   output phold_pkg::core_id_t  disp_core,
   output phold_pkg::lp_id_t    disp_lp,
   output phold_pkg::sim_time_t disp_time,
   output logic                 spawn_vld,
   output logic                 spawn_init,
   output phold_pkg::core_id_t  spawn_core,
   output phold_pkg::lp_id_t    spawn_lp,
   output phold_pkg::sim_time_t spawn_time
);
   import phold_pkg::*;

   run_state_t state;
   lp_id_t     init_cnt;   // next LP to seed
   logic       q_busy;     // queue op last cycle

   logic                 init_enq, spawn_enq, enq, deq, q_full, q_empty;
   lp_id_t               head_lp, in_lp;
   sim_time_t            head_time, in_time;
   logic [NB_QCOUNT-1:0] q_count;
   rand_t                rnd;

   logic [NUM_CORE-1:0] core_ready, core_req, core_busy, core_start, core_ack;
   lp_id_t              core_lp        [NUM_CORE];
   sim_time_t           core_spawn_tm  [NUM_CORE];
   sim_time_t           core_time      [NUM_CORE];

   logic                disp_gnt_vld, spawn_gnt_vld;
   core_id_t            disp_gnt_id, spawn_gnt_id;
   logic [NUM_CORE-1:0] disp_gnt_oh, spawn_gnt_oh;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= st_idle;
         init_cnt <= '0;
      end else begin
         case (state)
            st_idle: state <= st_init;
            st_init: begin
               if (init_enq) begin
                  init_cnt <= init_cnt + 1'b1;
                  if (init_cnt == lp_id_t'(NUM_LP - 1))
                     state <= st_running;
               end
            end
            st_running: begin
               if (gvt > end_time)
                  state <= st_finished;
            end
            st_finished: state <= st_finished;   // held until reset
            default:     state <= st_idle;
         endcase
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         q_busy <= 1'b0;
      else
         q_busy <= enq | deq;
   end

   // enqueue wins over dispatch, pending spawns drain after done
   assign q_full    = (q_count == NB_QCOUNT'(QUEUE_DEPTH));
   assign init_enq  = (state == st_init) && !q_busy && !q_full;
   assign spawn_enq = (state == st_running || state == st_finished)
                      && spawn_gnt_vld && !q_busy && !q_full;
   assign enq       = init_enq | spawn_enq;
   assign deq       = (state == st_running) && !q_empty && !q_busy && disp_gnt_vld && !enq;

   assign in_lp   = (state == st_init) ? init_cnt : core_lp[spawn_gnt_id];
   assign in_time = (state == st_init) ? '0 : core_spawn_tm[spawn_gnt_id];

   assign core_start = deq ? disp_gnt_oh : '0;
   assign core_ack   = spawn_enq ? spawn_gnt_oh : '0;

   // event log straight from the queue controls
   assign disp_vld   = deq;
   assign disp_core  = disp_gnt_id;
   assign disp_lp    = head_lp;
   assign disp_time  = head_time;
   assign spawn_vld  = enq;
   assign spawn_init = init_enq;
   assign spawn_core = (state == st_init) ? '0 : spawn_gnt_id;
   assign spawn_lp   = in_lp;
   assign spawn_time = in_time;
   assign done       = (state == st_finished);

   rr_arbiter i_disp_arb (
      .clk        (clk),
      .rst_n      (rst_n),
      .req        (core_ready),
      .used       (deq),
      .gnt_vld    (disp_gnt_vld),
      .gnt_id     (disp_gnt_id),
      .gnt_onehot (disp_gnt_oh)
   );

   rr_arbiter i_spawn_arb (
      .clk        (clk),
      .rst_n      (rst_n),
      .req        (core_req),
      .used       (spawn_enq),
      .gnt_vld    (spawn_gnt_vld),
      .gnt_id     (spawn_gnt_id),
      .gnt_onehot (spawn_gnt_oh)
   );

   event_queue i_queue (
      .clk       (clk),
      .rst_n     (rst_n),
      .enq       (enq),
      .deq       (deq),
      .in_lp     (in_lp),
      .in_time   (in_time),
      .head_lp   (head_lp),
      .head_time (head_time),
      .empty     (q_empty),
      .count     (q_count)
   );

   // fresh word for every dispatched event
   lfsr_prng i_prng (
      .clk   (clk),
      .rst_n (rst_n),
      .seed  (seed),
      .next  (deq),
      .rnd   (rnd)
   );

   for (genvar g = 0; g < NUM_CORE; g++) begin : gen_core
      phold_core i_core (
         .clk        (clk),
         .rst_n      (rst_n),
         .start      (core_start[g]),
         .start_lp   (head_lp),
         .start_time (head_time),
         .rnd        (rnd),
         .ready      (core_ready[g]),
         .spawn_req  (core_req[g]),
         .spawn_lp   (core_lp[g]),
         .spawn_time (core_spawn_tm[g]),
         .ack        (core_ack[g]),
         .busy       (core_busy[g]),
         .cur_time   (core_time[g])
      );
   end

   gvt_tracker i_gvt (
      .clk         (clk),
      .rst_n       (rst_n),
      .running     (state == st_running),
      .head_time   (head_time),
      .queue_empty (q_empty),
      .core_busy   (core_busy),
      .core_time   (core_time),
      .gvt         (gvt)
   );

endmodule

/* hw/gvt_tracker.sv */
`timescale 1ns/1ps

module gvt_tracker (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic                           running,
   input  phold_pkg::sim_time_t           head_time,
   input  logic                           queue_empty,
   input  logic [phold_pkg::NUM_CORE-1:0] core_busy,
   input  phold_pkg::sim_time_t           core_time [phold_pkg::NUM_CORE],
   output phold_pkg::sim_time_t           gvt
);
   import phold_pkg::*;

   sim_time_t min_time;
   logic      min_vld;

   // earliest time over the queue head and all in-flight events
   always_comb begin
      min_vld  = !queue_empty;
      min_time = head_time;
      for (int i = 0; i < NUM_CORE; i++) begin
         if (core_busy[i] && (!min_vld || core_time[i] < min_time)) begin
            min_vld  = 1'b1;
            min_time = core_time[i];
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         gvt <= '0;
      else if (running && min_vld)
         gvt <= min_time;   // no event can appear below this
   end

endmodule

/* hw/phold_core.sv */
`timescale 1ns/1ps

module phold_core (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 start,
   input  phold_pkg::lp_id_t    start_lp,
   input  phold_pkg::sim_time_t start_time,
   input  phold_pkg::rand_t     rnd,
   output logic                 ready,
   output logic                 spawn_req,
   output phold_pkg::lp_id_t    spawn_lp,
   output phold_pkg::sim_time_t spawn_time,
   input  logic                 ack,
   output logic                 busy,
   output phold_pkg::sim_time_t cur_time
);
   import phold_pkg::*;

   core_state_t        state;
   logic [NB_WORK-1:0] work_cnt;   // cycles left in cs_work, minus one
   lp_id_t             ev_lp;
   sim_time_t          ev_time;
   logic [NB_INC-1:0]  inc;
   logic               work_done;

   assign inc       = rnd[NB_WORK +: NB_INC];
   assign work_done = (state == cs_work) && (work_cnt == '0);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= cs_idle;
         work_cnt <= '0;
      end else begin
         case (state)
            cs_idle: begin
               if (start) begin
                  state    <= cs_work;
                  work_cnt <= rnd[NB_WORK-1:0];
               end
            end
            cs_work: begin
               if (work_cnt == '0)
                  state <= cs_spawn;
               else
                  work_cnt <= work_cnt - 1'b1;
            end
            cs_spawn: begin
               if (ack)
                  state <= cs_idle;   // successor taken by the queue
            end
            default: state <= cs_idle;
         endcase
      end
   end

   // event payload
   always_ff @(posedge clk) begin
      if (state == cs_idle && start) begin
         ev_lp   <= start_lp;
         ev_time <= start_time;
      end
      if (work_done) begin
         // random hop away from the owning LP, still uniform over all LPs
         spawn_lp   <= ev_lp + rnd[NB_RAND-1 -: NB_LP_ID];
         spawn_time <= ev_time + sim_time_t'(inc) + sim_time_t'(1);
      end
   end

   assign ready     = (state == cs_idle);
   assign spawn_req = (state == cs_spawn);
   assign busy      = (state != cs_idle);   // held event still counts for gvt
   assign cur_time  = ev_time;

endmodule

/* hw/lfsr_prng.sv */
`timescale 1ns/1ps

module lfsr_prng (
   input  logic              clk,
   input  logic              rst_n,
   input  phold_pkg::rand_t  seed,
   input  logic              next,
   output phold_pkg::rand_t  rnd
);
   import phold_pkg::*;

   // galois form of x^24 + x^23 + x^22 + x^17 + 1
   localparam rand_t TAPS = 24'hE1_0000;

   logic loaded;   // seed taken on the first edge out of reset

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         loaded <= 1'b0;
         rnd    <= rand_t'(1);
      end else if (!loaded) begin
         loaded <= 1'b1;
         rnd    <= (seed == '0) ? rand_t'(1) : seed;   // all-zero state would lock up
      end else if (next) begin
         rnd <= (rnd >> 1) ^ (rnd[0] ? TAPS : '0);
      end
   end

endmodule

/* hw/event_queue.sv */
`timescale 1ns/1ps

module event_queue (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic                            enq,
   input  logic                            deq,
   input  phold_pkg::lp_id_t               in_lp,
   input  phold_pkg::sim_time_t            in_time,
   output phold_pkg::lp_id_t               head_lp,
   output phold_pkg::sim_time_t            head_time,
   output logic                            empty,
   output logic [phold_pkg::NB_QCOUNT-1:0] count
);
   import phold_pkg::*;

   lp_id_t    q_lp   [QUEUE_DEPTH];
   sim_time_t q_time [QUEUE_DEPTH];

   logic [QUEUE_DEPTH-1:0] stay;       // entry not later than the new one
   logic [QUEUE_DEPTH-1:0] prev_stay;
   logic [QUEUE_DEPTH-1:0] ins_at;
   logic [QUEUE_DEPTH-1:0] shift_up;

   // sorted array, so stay is a thermometer from slot 0
   always_comb begin
      for (int i = 0; i < QUEUE_DEPTH; i++)
         stay[i] = (i < count) && (q_time[i] <= in_time);
   end

   assign prev_stay = {stay[QUEUE_DEPTH-2:0], 1'b1};
   assign ins_at    = ~stay & prev_stay;   // first later slot, behind equal times
   assign shift_up  = ~prev_stay;

   always_ff @(posedge clk) begin
      if (enq) begin
         for (int i = 0; i < QUEUE_DEPTH; i++) begin
            if (ins_at[i]) begin
               q_lp[i]   <= in_lp;
               q_time[i] <= in_time;
            end
         end
         for (int i = 1; i < QUEUE_DEPTH; i++) begin
            if (shift_up[i]) begin
               q_lp[i]   <= q_lp[i-1];
               q_time[i] <= q_time[i-1];
            end
         end
      end else if (deq) begin
         // pop the head, everything moves down one slot
         for (int i = 0; i < QUEUE_DEPTH - 1; i++) begin
            q_lp[i]   <= q_lp[i+1];
            q_time[i] <= q_time[i+1];
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         count <= '0;
      end else if (enq) begin
         if (count != NB_QCOUNT'(QUEUE_DEPTH))
            count <= count + 1'b1;
      end else if (deq && !empty) begin
         count <= count - 1'b1;
      end
   end

   assign head_lp   = q_lp[0];
   assign head_time = q_time[0];
   assign empty     = (count == '0);

endmodule

/* hw/rr_arbiter.sv */
`timescale 1ns/1ps

module rr_arbiter (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic [phold_pkg::NUM_CORE-1:0] req,
   input  logic                           used,
   output logic                           gnt_vld,
   output phold_pkg::core_id_t            gnt_id,
   output logic [phold_pkg::NUM_CORE-1:0] gnt_onehot
);
   import phold_pkg::*;

   core_id_t            ptr;       // highest priority requester
   core_id_t            next_ptr;
   core_id_t            search;
   core_id_t            idx;
   logic [NUM_CORE-1:0] req_eff;
   logic                pick_vld;
   core_id_t            pick_id;
   logic                hold;

   assign next_ptr = core_id_t'(gnt_id + 1'b1);
   assign hold     = gnt_vld && req[gnt_id] && !used;

   // index wraps by width, NUM_CORE is a power of two
   always_comb begin
      req_eff  = used ? (req & ~gnt_onehot) : req;   // winner just served
      search   = used ? next_ptr : ptr;
      pick_vld = 1'b0;
      pick_id  = search;
      idx      = search;
      for (int i = NUM_CORE - 1; i >= 0; i--) begin
         idx = core_id_t'(search + i);
         if (req_eff[idx]) begin
            pick_vld = 1'b1;
            pick_id  = idx;
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ptr        <= '0;
         gnt_vld    <= 1'b0;
         gnt_id     <= '0;
         gnt_onehot <= '0;
      end else begin
         if (used)
            ptr <= next_ptr;   // rotate past the served core
         if (!hold) begin
            gnt_vld    <= pick_vld;
            gnt_id     <= pick_id;
            gnt_onehot <= pick_vld ? (NUM_CORE'(1) << pick_id) : '0;
         end
      end
   end

endmodule

/* hw/phold_pkg.sv */
package phold_pkg;

   // core array
   localparam int NUM_CORE   = 4;
   localparam int NB_CORE_ID = 2;

   // logical processes
   localparam int NUM_LP   = 8;
   localparam int NB_LP_ID = 3;

   localparam int TIME_WID = 16;

   // room for every LP event plus one held per core
   localparam int QUEUE_DEPTH = 16;
   localparam int NB_QCOUNT   = 5;

   // random source and the fields cut from it
   localparam int NB_RAND = 24;
   localparam int NB_INC  = 3;   // increment is field + 1
   localparam int NB_WORK = 3;   // work cycles are field + 1

   typedef logic [TIME_WID-1:0]   sim_time_t;
   typedef logic [NB_LP_ID-1:0]   lp_id_t;
   typedef logic [NB_CORE_ID-1:0] core_id_t;
   typedef logic [NB_RAND-1:0]    rand_t;

   typedef enum logic [1:0] {
      st_idle,
      st_init,       // loading one event per LP
      st_running,
      st_finished    // done held until reset
   } run_state_t;

   typedef enum logic [1:0] {
      cs_idle,
      cs_work,
      cs_spawn
   } core_state_t;

endpackage
